//--- logic/sched_regs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Scheduler job registers
// Register indices, field layout and quantization formats
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package sched_regs_pkg;

  localparam int unsigned NUM_REGS = 12;

  // Word positions in the job register block
  localparam int unsigned X_ADDR       = 0;
  localparam int unsigned W_ADDR       = 1;
  localparam int unsigned Z_ADDR       = 2;
  localparam int unsigned SCALES_ADDR  = 3;
  localparam int unsigned X_ITERS      = 4;
  localparam int unsigned W_ITERS      = 5;
  localparam int unsigned TOT_X_READ   = 6;
  localparam int unsigned X_ROWS_OFFS  = 7;
  localparam int unsigned LEFTOVERS    = 8;
  localparam int unsigned X_D1_STRIDE  = 9;
  localparam int unsigned W_D0_STRIDE  = 10;
  localparam int unsigned DEQUANT_MODE = 11;

  // Iteration counts are packed two per word
  localparam int unsigned ITER_W       = 16;
  localparam int unsigned LEFTOVER_LSB = 24;
  localparam int unsigned LEFTOVER_W   = 8;
  localparam int unsigned DQ_EN_BIT    = 0;
  localparam int unsigned DQ_FMT_LSB   = 1;
  localparam int unsigned QFMT_W       = 2;

  typedef logic [NUM_REGS-1:0][31:0] sched_regs_t;

  typedef enum logic [QFMT_W-1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  localparam int unsigned GW = 8;

  // Group index with its skip flag on top
  typedef logic [GW:0] gidx_word_t;

endpackage

`default_nettype wire

//--- logic/stream_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Stream address-generator settings
// Settings struct and memory geometry of the streams
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package stream_cfg_pkg;

  // Memory beat and data word widths in bits
  localparam int unsigned MEM_DW   = 32;
  localparam int unsigned DATA_W   = 256;
  localparam int unsigned NUM_BYTE = MEM_DW / 8;

  // Byte step between adjacent tiles
  localparam int unsigned JMP = NUM_BYTE * (DATA_W / MEM_DW);

  // Two-dimensional walk, d0 and d1 active
  localparam logic [2:0] CFG_DIM_2D = 3'b011;

  typedef struct packed {
    logic [31:0] base_addr;
    logic [31:0] tot_len;
    logic [15:0] d0_len;
    logic [31:0] d0_stride;
    logic [15:0] d1_len;
    logic [31:0] d1_stride;
    logic [2:0]  dim_enable;
  } addrgen_cfg_t;

endpackage

`default_nettype wire

//--- logic/tile_pos_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// X tile position
// Walker state seen by the configuration generator
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface tile_pos_if;

  logic [31:0] col_offs;
  logic [31:0] row_offs;
  logic [15:0] num_x_reads;
  logic        reads_pending;

  modport walker (
    output col_offs, row_offs, num_x_reads, reads_pending
  );

  modport cfg (
    input col_offs, row_offs, num_x_reads, reads_pending
  );

endinterface

`default_nettype wire

//--- logic/x_tile_walker.sv
// ~~~~~~~~~~~~~~~~~~~~
// X tile walker
// Column, W-pass and row counters with their byte offsets,
// plus the running count of X reads
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module x_tile_walker
  import sched_regs_pkg::*;
  import stream_cfg_pkg::*;
#(
  parameter int unsigned ARRAY_W = 12
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        x_done_i,
  input  sched_regs_t regs_i,
  tile_pos_if.walker  pos_o
);

  logic [ITER_W-1:0]     col_last_idx;
  logic [ITER_W-1:0]     pass_last_idx;
  logic [ITER_W-1:0]     row_last_idx;
  logic [ITER_W-1:0]     col_cnt_q;
  logic [ITER_W-1:0]     pass_cnt_q;
  logic [ITER_W-1:0]     row_cnt_q;
  logic [ITER_W-1:0]     tot_reads_q;
  logic [31:0]           col_offs_q;
  logic [31:0]           row_offs_q;
  logic [LEFTOVER_W-1:0] leftover;
  logic                  col_wrap;
  logic                  pass_wrap;
  logic                  row_last;

  assign col_last_idx  = regs_i[X_ITERS][0 +: ITER_W] - 16'd1;
  assign row_last_idx  = regs_i[X_ITERS][ITER_W +: ITER_W] - 16'd1;
  assign pass_last_idx = regs_i[W_ITERS][0 +: ITER_W] - 16'd1;

  assign col_wrap  = col_cnt_q == col_last_idx;
  assign pass_wrap = pass_cnt_q == pass_last_idx;
  assign row_last  = row_cnt_q == row_last_idx;

  assign leftover = regs_i[LEFTOVERS][LEFTOVER_LSB +: LEFTOVER_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin : tile_counters
    if (!rst_ni) begin
      col_cnt_q   <= '0;
      pass_cnt_q  <= '0;
      row_cnt_q   <= '0;
      col_offs_q  <= '0;
      row_offs_q  <= '0;
      tot_reads_q <= '0;
    end else if (clear_i) begin
      col_cnt_q   <= '0;
      pass_cnt_q  <= '0;
      row_cnt_q   <= '0;
      col_offs_q  <= '0;
      row_offs_q  <= '0;
      tot_reads_q <= '0;
    end else if (x_done_i) begin
      tot_reads_q <= tot_reads_q + 16'd1;
      col_cnt_q   <= col_wrap ? '0 : col_cnt_q + 16'd1;
      col_offs_q  <= col_wrap ? '0 : col_offs_q + JMP;
      if (col_wrap) begin
        pass_cnt_q <= pass_wrap ? '0 : pass_cnt_q + 16'd1;
      end
      // Next row only once every W pass has seen all columns
      if (col_wrap && pass_wrap) begin
        row_cnt_q  <= row_last ? '0 : row_cnt_q + 16'd1;
        row_offs_q <= row_last ? '0 : row_offs_q + regs_i[X_ROWS_OFFS];
      end
    end
  end

  assign pos_o.col_offs = col_offs_q;
  assign pos_o.row_offs = row_offs_q;

  // Short last row reads only the leftover count
  assign pos_o.num_x_reads = (row_last && leftover != '0) ? {8'd0, leftover}
                                                          : 16'(ARRAY_W);

  assign pos_o.reads_pending = (tot_reads_q != '0) &&
                               (32'(tot_reads_q) != regs_i[TOT_X_READ]);

endmodule

`default_nettype wire

//--- logic/stream_cfg_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Stream configuration
// X, W and Z address-generator settings and start requests
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module stream_cfg_gen
  import sched_regs_pkg::*;
  import stream_cfg_pkg::*;
#(
  parameter int unsigned ARRAY_W = 12
) (
  input  sched_regs_t  regs_i,
  input  logic         first_load_i,
  input  logic         idle_i,
  input  logic         x_ready_i,
  input  logic         w_ready_i,
  input  logic         z_ready_i,
  tile_pos_if.cfg      pos_i,
  output addrgen_cfg_t x_cfg_o,
  output addrgen_cfg_t w_cfg_o,
  output addrgen_cfg_t z_cfg_o,
  output logic         x_req_start_o,
  output logic         w_req_start_o,
  output logic         z_req_start_o
);

  logic [ITER_W-1:0] w_passes;
  logic [ITER_W-1:0] w_depth;
  logic              dequant_en;

  assign w_passes   = regs_i[W_ITERS][0 +: ITER_W];
  assign w_depth    = regs_i[W_ITERS][ITER_W +: ITER_W];
  assign dequant_en = regs_i[DEQUANT_MODE][DQ_EN_BIT];

  always_comb begin : x_cfg
    x_cfg_o.base_addr  = regs_i[X_ADDR] + pos_i.row_offs + pos_i.col_offs;
    x_cfg_o.tot_len    = 32'(pos_i.num_x_reads);
    x_cfg_o.d0_len     = 16'd1;
    x_cfg_o.d0_stride  = '0;
    x_cfg_o.d1_len     = 16'(ARRAY_W);
    x_cfg_o.d1_stride  = regs_i[X_D1_STRIDE];
    x_cfg_o.dim_enable = CFG_DIM_2D;
  end

  // In dequantization mode the W stream fetches the scales
  always_comb begin : w_cfg
    w_cfg_o.base_addr  = dequant_en ? regs_i[SCALES_ADDR] : regs_i[W_ADDR];
    w_cfg_o.tot_len    = 32'(w_depth) * 32'(w_passes);
    w_cfg_o.d0_len     = w_depth;
    w_cfg_o.d0_stride  = dequant_en ? '0 : regs_i[W_D0_STRIDE];
    w_cfg_o.d1_len     = w_passes;
    w_cfg_o.d1_stride  = JMP;
    w_cfg_o.dim_enable = CFG_DIM_2D;
  end

  always_comb begin : z_cfg
    z_cfg_o.base_addr  = regs_i[Z_ADDR];
    z_cfg_o.tot_len    = 32'(ARRAY_W) * 32'(w_passes);
    z_cfg_o.d0_len     = 16'(ARRAY_W);
    z_cfg_o.d0_stride  = JMP;
    z_cfg_o.d1_len     = w_passes;
    z_cfg_o.d1_stride  = '0;
    z_cfg_o.dim_enable = CFG_DIM_2D;
  end

  // X restarts on its own while reads of the job are still outstanding
  assign x_req_start_o = !idle_i && (first_load_i || pos_i.reads_pending) && x_ready_i;
  assign w_req_start_o = first_load_i && w_ready_i;
  assign z_req_start_o = first_load_i && z_ready_i;

endmodule

`default_nettype wire

//--- logic/dequant_offset_calc.sv
// ~~~~~~~~~~~~~~~~~~~~
// Dequantization offsets
// Group index and row number to scales, zeros and wq byte offsets
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dequant_offset_calc
  import sched_regs_pkg::*;
(
  input  sched_regs_t regs_i,
  input  logic        gidx_valid_i,
  input  gidx_word_t  gidx_data_i,
  input  logic        bias_ready_i,
  input  logic        row_valid_i,
  input  logic [15:0] row_data_i,
  input  logic        wq_ready_i,
  output logic        gidx_ready_o,
  output logic        bias_valid_o,
  output logic [31:0] scales_bias_o,
  output logic [31:0] zeros_bias_o,
  output logic        group_skip_o,
  output logic        row_ready_o,
  output logic        wq_valid_o,
  output logic [31:0] wq_bias_o
);

  qint_fmt_e   q_fmt;
  logic [1:0]  q_shift;
  logic [15:0] w_stride;
  logic [15:0] packed_stride;

  assign q_fmt = qint_fmt_e'(regs_i[DEQUANT_MODE][DQ_FMT_LSB +: QFMT_W]);

  // Narrower formats pack more weights per byte
  always_comb begin
    case (q_fmt)
      QINT_2:  q_shift = 2'd3;
      QINT_4:  q_shift = 2'd2;
      default: q_shift = 2'd1;
    endcase
  end

  assign w_stride      = regs_i[W_D0_STRIDE][15:0];
  assign packed_stride = w_stride >> q_shift;

  assign scales_bias_o = 32'(gidx_data_i[GW-1:0]) * 32'(w_stride);
  assign zeros_bias_o  = 32'(gidx_data_i[GW-1:0]) * 32'(packed_stride);
  assign group_skip_o  = gidx_data_i[GW];

  // Scales and zeros share one ready
  assign gidx_ready_o = bias_ready_i;
  assign bias_valid_o = gidx_valid_i && bias_ready_i;

  assign wq_bias_o   = 32'(row_data_i) * 32'(packed_stride);
  assign row_ready_o = wq_ready_i;
  assign wq_valid_o  = row_valid_i && wq_ready_i;

endmodule

`default_nettype wire

//--- logic/mem_sched_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Memory scheduler
// Tile walker, stream settings and dequantization offsets
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mem_sched_top
  import sched_regs_pkg::*;
  import stream_cfg_pkg::*;
#(
  parameter int unsigned ARRAY_W = 12
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  sched_regs_t  regs_i,
  input  logic         x_done_i,
  input  logic         first_load_i,
  input  logic         idle_i,
  input  logic         x_ready_i,
  input  logic         w_ready_i,
  input  logic         z_ready_i,
  input  logic         gidx_valid_i,
  input  gidx_word_t   gidx_data_i,
  input  logic         bias_ready_i,
  input  logic         row_valid_i,
  input  logic [15:0]  row_data_i,
  input  logic         wq_ready_i,
  output addrgen_cfg_t x_cfg_o,
  output addrgen_cfg_t w_cfg_o,
  output addrgen_cfg_t z_cfg_o,
  output logic         x_req_start_o,
  output logic         w_req_start_o,
  output logic         z_req_start_o,
  output logic         gidx_ready_o,
  output logic         bias_valid_o,
  output logic [31:0]  scales_bias_o,
  output logic [31:0]  zeros_bias_o,
  output logic         group_skip_o,
  output logic         row_ready_o,
  output logic         wq_valid_o,
  output logic [31:0]  wq_bias_o
);

  tile_pos_if tile_pos ();

  x_tile_walker #(
    .ARRAY_W (ARRAY_W)
  ) u_x_tile_walker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .x_done_i (x_done_i),
    .regs_i   (regs_i),
    .pos_o    (tile_pos.walker)
  );

  stream_cfg_gen #(
    .ARRAY_W (ARRAY_W)
  ) u_stream_cfg_gen (
    .regs_i        (regs_i),
    .first_load_i  (first_load_i),
    .idle_i        (idle_i),
    .x_ready_i     (x_ready_i),
    .w_ready_i     (w_ready_i),
    .z_ready_i     (z_ready_i),
    .pos_i         (tile_pos.cfg),
    .x_cfg_o       (x_cfg_o),
    .w_cfg_o       (w_cfg_o),
    .z_cfg_o       (z_cfg_o),
    .x_req_start_o (x_req_start_o),
    .w_req_start_o (w_req_start_o),
    .z_req_start_o (z_req_start_o)
  );

  dequant_offset_calc u_dequant_offset_calc (
    .regs_i        (regs_i),
    .gidx_valid_i  (gidx_valid_i),
    .gidx_data_i   (gidx_data_i),
    .bias_ready_i  (bias_ready_i),
    .row_valid_i   (row_valid_i),
    .row_data_i    (row_data_i),
    .wq_ready_i    (wq_ready_i),
    .gidx_ready_o  (gidx_ready_o),
    .bias_valid_o  (bias_valid_o),
    .scales_bias_o (scales_bias_o),
    .zeros_bias_o  (zeros_bias_o),
    .group_skip_o  (group_skip_o),
    .row_ready_o   (row_ready_o),
    .wq_valid_o    (wq_valid_o),
    .wq_bias_o     (wq_bias_o)
  );

endmodule

`default_nettype wire

//--- test/mem_sched_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~
// Memory scheduler checks
// Handshake rules and walker state after reset or clear
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mem_sched_assertions (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        clear_i,
  input logic [31:0] col_offs_i,
  input logic [31:0] row_offs_i,
  input logic        reads_pending_i,
  input logic        bias_valid_i,
  input logic        bias_ready_i,
  input logic        wq_valid_i,
  input logic        wq_ready_i
);

  // Offsets are only offered to a ready consumer
  bias_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bias_valid_i |-> bias_ready_i)
    else $error("bias_valid_o high while bias_ready_i is low");

  wq_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wq_valid_i |-> wq_ready_i)
    else $error("wq_valid_o high while wq_ready_i is low");

  reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (col_offs_i == '0 && row_offs_i == '0 && !reads_pending_i))
    else $error("walker state not zero when reset is released");

  clear_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (col_offs_i == '0 && row_offs_i == '0 && !reads_pending_i))
    else $error("walker state not zero after clear");

endmodule

// Walker position and dequantization handshakes seen from the top level
bind mem_sched_top mem_sched_assertions u_mem_sched_assertions (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .clear_i         (clear_i),
  .col_offs_i      (tile_pos.col_offs),
  .row_offs_i      (tile_pos.row_offs),
  .reads_pending_i (tile_pos.reads_pending),
  .bias_valid_i    (bias_valid_o),
  .bias_ready_i    (bias_ready_i),
  .wq_valid_i      (wq_valid_o),
  .wq_ready_i      (wq_ready_i)
);

`default_nettype wire

//--- test/mem_sched_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Memory scheduler testbench
// Replays job records from a data file and checks the DUT
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mem_sched_tb
  import sched_regs_pkg::*;
  import stream_cfg_pkg::*;
();

  localparam int unsigned ARRAY_W    = 12;
  localparam int unsigned HS_TIMEOUT = 8;
  localparam int unsigned MAX_RECS   = 1000;
  localparam string       DATA_FILE  = "test/mem_sched_testdata.txt";

  logic clk_i, rst_ni, clear_i, x_done_i, first_load_i, idle_i;
  logic x_ready_i, w_ready_i, z_ready_i;
  logic gidx_valid_i, bias_ready_i, row_valid_i, wq_ready_i;
  logic [15:0]  row_data_i;
  gidx_word_t   gidx_data_i;
  sched_regs_t  regs_i;
  addrgen_cfg_t x_cfg_o, w_cfg_o, z_cfg_o;
  logic x_req_start_o, w_req_start_o, z_req_start_o;
  logic gidx_ready_o, bias_valid_o, group_skip_o, row_ready_o, wq_valid_o;
  logic [31:0] scales_bias_o, zeros_bias_o, wq_bias_o;

  int          fd;
  int unsigned num_checks;
  logic [31:0] fld [14];

  mem_sched_top #(.ARRAY_W (ARRAY_W)) u_mem_sched_top (.*);

  always #4 clk_i = ~clk_i;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic compare_cfg(input string name, input addrgen_cfg_t act, input addrgen_cfg_t exp);
    num_checks++;
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, act, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    num_checks++;
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, act, exp));
    end
  endtask

  task automatic compare_offset(input string name, input logic [31:0] act,
                                input logic [31:0] exp);
    num_checks++;
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, act, exp));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic wait_drive_slot();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_for_valid(input bit on_wq);
    int unsigned polls;
    polls = 0;
    while ((on_wq ? wq_valid_o : bias_valid_o) !== 1'b1 && polls < HS_TIMEOUT) begin
      @(negedge clk_i);
      polls++;
    end
    if ((on_wq ? wq_valid_o : bias_valid_o) !== 1'b1) begin
      fail_run($sformatf("Timed out waiting for %s", on_wq ? "wq_valid_o" : "bias_valid_o"));
    end
  endtask

  task automatic read_fields(input int unsigned count);
    int          got;
    int unsigned i;
    for (i = 0; i < count; i++) begin
      got = $fscanf(fd, "%h", fld[i]);
      if (got != 1) begin
        fail_run("Test data record is missing a field");
      end
    end
  endtask

  // X walk: d0 is a single beat, d1 spans the array rows
  task automatic check_x_cfg(input logic [31:0] base, input logic [31:0] tot);
    addrgen_cfg_t exp;
    exp.base_addr  = base;
    exp.tot_len    = tot;
    exp.d0_len     = 16'd1;
    exp.d0_stride  = '0;
    exp.d1_len     = 16'(ARRAY_W);
    exp.d1_stride  = regs_i[X_D1_STRIDE];
    exp.dim_enable = 3'b011;
    compare_cfg("x_cfg_o", x_cfg_o, exp);
  endtask

  task automatic check_w_z_cfg(input logic [31:0] w_base, input logic [31:0] w_stride);
    addrgen_cfg_t w_exp;
    addrgen_cfg_t z_exp;
    logic [15:0]  passes;
    logic [15:0]  depth;
    passes = regs_i[W_ITERS][15:0];
    depth  = regs_i[W_ITERS][31:16];
    @(negedge clk_i);
    w_exp = '{base_addr: w_base, tot_len: 32'(depth) * 32'(passes), d0_len: depth,
              d0_stride: w_stride, d1_len: passes, d1_stride: JMP, dim_enable: 3'b011};
    z_exp = '{base_addr: regs_i[Z_ADDR], tot_len: 32'(ARRAY_W) * 32'(passes),
              d0_len: 16'(ARRAY_W), d0_stride: JMP, d1_len: passes, d1_stride: '0,
              dim_enable: 3'b011};
    compare_cfg("w_cfg_o", w_cfg_o, w_exp);
    compare_cfg("z_cfg_o", z_cfg_o, z_exp);
  endtask

  task automatic run_dequant_case();
    wait_drive_slot();
    gidx_valid_i = fld[0][0];
    gidx_data_i  = fld[1][GW:0];
    bias_ready_i = fld[2][0];
    row_valid_i  = fld[3][0];
    row_data_i   = fld[4][15:0];
    wq_ready_i   = fld[5][0];
    @(negedge clk_i);
    compare_bit("gidx_ready_o", gidx_ready_o, fld[6][0]);
    compare_bit("row_ready_o", row_ready_o, fld[11][0]);
    if (fld[7][0]) begin
      wait_for_valid(1'b0);
      compare_offset("scales_bias_o", scales_bias_o, fld[8]);
      compare_offset("zeros_bias_o", zeros_bias_o, fld[9]);
      compare_bit("group_skip_o", group_skip_o, fld[10][0]);
    end else begin
      compare_bit("bias_valid_o", bias_valid_o, 1'b0);
    end
    if (fld[12][0]) begin
      wait_for_valid(1'b1);
      compare_offset("wq_bias_o", wq_bias_o, fld[13]);
    end else begin
      compare_bit("wq_valid_o", wq_valid_o, 1'b0);
    end
  endtask

  task automatic run_record(input logic [31:0] kind);
    case (kind)
      32'h1: begin
        read_fields(2);
        if (fld[0] >= NUM_REGS) fail_run("Register index out of range in test data");
        wait_drive_slot();
        regs_i[fld[0][3:0]] = fld[1];
      end
      32'h2, 32'h3: begin
        read_fields(2);
        // Move the walker off its first tile before a clear
        if (kind == 32'h2) begin
          wait_drive_slot();
          x_done_i = 1'b1;
        end
        wait_drive_slot();
        x_done_i = (kind == 32'h3);
        clear_i  = (kind == 32'h2);
        wait_drive_slot();
        clear_i  = 1'b0;
        x_done_i = 1'b0;
        @(negedge clk_i);
        check_x_cfg(fld[0], fld[1]);
      end
      32'h4: begin
        read_fields(8);
        wait_drive_slot();
        {idle_i, first_load_i, x_ready_i} = {fld[0][0], fld[1][0], fld[2][0]};
        {w_ready_i, z_ready_i} = {fld[3][0], fld[4][0]};
        @(negedge clk_i);
        compare_bit("x_req_start_o", x_req_start_o, fld[5][0]);
        compare_bit("w_req_start_o", w_req_start_o, fld[6][0]);
        compare_bit("z_req_start_o", z_req_start_o, fld[7][0]);
      end
      32'h5: begin
        read_fields(2);
        check_w_z_cfg(fld[0], fld[1]);
      end
      32'h6: begin
        read_fields(14);
        run_dequant_case();
      end
      default: fail_run($sformatf("Unknown record kind %0h in test data", kind));
    endcase
  endtask

  initial begin : stimulus
    logic [31:0] kind;
    int          got;
    int unsigned recs;
    {clk_i, rst_ni, clear_i, x_done_i, first_load_i, idle_i} = '0;
    {x_ready_i, w_ready_i, z_ready_i} = '0;
    {gidx_valid_i, bias_ready_i, row_valid_i, wq_ready_i} = '0;
    gidx_data_i = '0;
    row_data_i  = '0;
    regs_i      = '0;
    num_checks  = 0;
    recs        = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) fail_run("Could not open the test data file");
    while (!$feof(fd) && recs < MAX_RECS) begin
      got = $fscanf(fd, "%h", kind);
      if (got == 1) begin
        run_record(kind);
      end else if (!$feof(fd)) begin
        fail_run("Malformed record in test data");
      end
      recs++;
    end
    $fclose(fd);
    if (num_checks == 0) begin
      fail_run("No checks were run");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- all.f
logic/sched_regs_pkg.sv
logic/stream_cfg_pkg.sv
logic/tile_pos_if.sv
logic/x_tile_walker.sv
logic/stream_cfg_gen.sv
logic/dequant_offset_calc.sv
logic/mem_sched_top.sv
test/mem_sched_assertions.sv
test/mem_sched_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_sched_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Simulation completed successfully

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/mem_sched_testdata.txt
1 0 00001000
1 1 00002000
1 2 00003000
1 3 00004000
1 4 00020003
1 5 00040002
1 6 0000000C
1 7 00000100
1 8 05000000
1 9 00000040
1 A 00000060
2 00001000 0000000C
4 0 1 1 1 1 1 1 1
4 0 0 1 1 1 0 0 0
4 1 1 1 0 1 0 0 1
3 00001020 0000000C
4 0 0 1 1 1 1 0 0
4 1 0 1 1 1 0 0 0
3 00001040 0000000C
3 00001000 0000000C
3 00001020 0000000C
3 00001040 0000000C
3 00001100 00000005
3 00001120 00000005
3 00001140 00000005
3 00001100 00000005
3 00001120 00000005
3 00001140 00000005
3 00001000 0000000C
4 0 0 1 1 1 0 0 0
4 0 1 1 0 1 1 0 1
5 00002000 00000060
1 B 00000001
5 00004000 00000000
6 1 005 1 1 0007 1 1 1 000001E0 000000F0 0 1 1 00000150
6 1 10A 1 1 0002 1 1 1 000003C0 000001E0 1 1 1 00000060
1 B 00000003
6 1 003 1 1 0010 1 1 1 00000120 00000048 0 1 1 00000180
1 B 00000005
6 1 0FF 1 1 0100 1 1 1 00005FA0 00000BF4 0 1 1 00000C00
6 1 0FF 0 1 0003 0 0 0 00000000 00000000 0 0 0 00000000
6 0 003 1 1 0003 1 1 0 00000000 00000000 0 1 1 00000024
